// File: lspc_cfg.svh
//============================================================
// Slot numbers must be distinct and below SLOT_COUNT
// VRAM holds 2**VRAM_AW words of VRAM_DW bits, all on chip
//============================================================
`ifndef LSPC_CFG_SVH
`define LSPC_CFG_SVH

//============================================================
// Access slot timing
//============================================================

// Clock cycles in one access period
`define SLOT_COUNT 8

// Slot that serves the video fetch side
`define VIDEO_SLOT 2

// Slot that serves the CPU port
`define CPU_SLOT 6

//============================================================
// VRAM geometry
//============================================================

// Word address width
`define VRAM_AW 11

// Word width
`define VRAM_DW 16

`endif

// File: lspcCpuPkg.sv
//============================================================
// CPU side of the VRAM port
// Requests are valid only in the cycle where strobe is high
//============================================================
`default_nettype none

`include "lspc_cfg.svh"

package lspcCpuPkg;

	// Register select
	// Follows the CPU register order of the LSPC
	typedef enum logic [1:0] {
		REG_VRAMADDR = 2'd0,
		REG_VRAMRW   = 2'd1,
		REG_VRAMMOD  = 2'd2
	} cpuReg_e;

	// One CPU register write
	// 19 bits in all
	typedef struct packed {
		// Single-cycle write strobe
		logic                strobe;
		// Target register
		cpuReg_e             sel;
		// Written value
		logic [`VRAM_DW-1:0] data;
	} cpuReq_t;

endpackage

`default_nettype wire

// File: lspcVramPkg.sv
//============================================================
// VRAM access types shared by the sequencer and the array
// Only one of the two enables is set in any cycle
//============================================================
`default_nettype none

`include "lspc_cfg.svh"

package lspcVramPkg;

	// CPU access sequencer states
	typedef enum logic [1:0] {
		IDLE          = 2'd0,
		WRITE_WAIT    = 2'd1,
		PREFETCH_WAIT = 2'd2
	} seqState_e;

	// One memory access in a CPU slot
	// 29 bits in all
	typedef struct packed {
		// Store data at addr
		logic                wrEn;
		// Prefetch word at addr
		logic                rdEn;
		logic [`VRAM_AW-1:0] addr;
		logic [`VRAM_DW-1:0] data;
	} memAccess_t;

endpackage

`default_nettype wire

// File: slotTimer.sv
//============================================================
// Free running after reset with no way to resync
//============================================================
`timescale 1ns/100ps
`default_nettype none

`include "lspc_cfg.svh"

module slotTimer (
	input  wire  CLK,
	input  wire  nRESETP,
	output logic videoSlot,
	output logic cpuSlot
);

	localparam int CntW = $clog2(`SLOT_COUNT);

	// Current slot number
	logic [CntW-1:0] slotCnt;
	logic [CntW-1:0] slotNext;

	// Wrap at the end of the period
	always_comb begin
		if (slotCnt == CntW'(`SLOT_COUNT - 1)) begin
			slotNext = '0;
		end else begin
			slotNext = slotCnt + 1'b1;
		end
	end

	// Strobes decoded from the next count so they line up with slotCnt
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			slotCnt   <= '0;
			videoSlot <= 1'b0;
			cpuSlot   <= 1'b0;
		end else begin
			slotCnt   <= slotNext;
			videoSlot <= (slotNext == CntW'(`VIDEO_SLOT));
			cpuSlot   <= (slotNext == CntW'(`CPU_SLOT));
		end
	end

endmodule

`default_nettype wire

// File: vramSequencer.sv
//============================================================
// Strobes are taken only in IDLE and dropped while busy
// Write then advance then prefetch each wait for a CPU slot
//============================================================
`timescale 1ns/100ps
`default_nettype none

`include "lspc_cfg.svh"

module vramSequencer import lspcCpuPkg::*, lspcVramPkg::*; (
	input  wire                       CLK,
	input  wire                       nRESETP,
	input  wire cpuReq_t              cpuReq,
	input  wire                       cpuSlot,
	input  wire [`VRAM_AW-1:0]        curAddr,
	input  wire [`VRAM_DW-1:0]        wrData,
	output memAccess_t                memReq,
	output logic                      advance,
	output logic                      busy
);

	seqState_e state;
	seqState_e stateNext;
	logic      accept;

	// Any sequence in flight blocks new strobes
	assign busy   = (state != IDLE);
	assign accept = cpuReq.strobe && !busy;

	//============================================================
	// Next state
	//============================================================
	always_comb begin
		stateNext = state;
		case (state)
			IDLE: begin
				// Modulo writes never leave IDLE
				if (accept && (cpuReq.sel == REG_VRAMRW)) begin
					stateNext = WRITE_WAIT;
				end else if (accept && (cpuReq.sel == REG_VRAMADDR)) begin
					stateNext = PREFETCH_WAIT;
				end
			end
			WRITE_WAIT: begin
				if (cpuSlot) begin
					stateNext = PREFETCH_WAIT;
				end
			end
			PREFETCH_WAIT: begin
				if (cpuSlot) begin
					stateNext = IDLE;
				end
			end
			default: begin
				stateNext = IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			state   <= IDLE;
			advance <= 1'b0;
		end else begin
			state   <= stateNext;
			// One pulse right after the write slot
			advance <= (state == WRITE_WAIT) && cpuSlot;
		end
	end

	// Enables only ever inside a CPU slot
	always_comb begin
		memReq.wrEn = (state == WRITE_WAIT) && cpuSlot;
		memReq.rdEn = (state == PREFETCH_WAIT) && cpuSlot;
		memReq.addr = curAddr;
		memReq.data = wrData;
	end

endmodule

`default_nettype wire

// File: vramAddrRegs.sv
//============================================================
// Address and modulo are VRAM_AW wide and the sum wraps
// Upper data bits are dropped when loading either of them
//============================================================
`timescale 1ns/100ps
`default_nettype none

`include "lspc_cfg.svh"

module vramAddrRegs import lspcCpuPkg::*; (
	input  wire                       CLK,
	input  wire                       nRESETP,
	input  wire cpuReq_t              cpuReq,
	input  wire                       busy,
	input  wire                       advance,
	output logic [`VRAM_AW-1:0]       curAddr,
	output logic [`VRAM_DW-1:0]       wrData
);

	// Step added after each data write
	logic [`VRAM_AW-1:0] modulo;
	logic                accept;

	// Same acceptance rule as the sequencer
	assign accept = cpuReq.strobe && !busy;

	//============================================================
	// Address and modulo
	//============================================================
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			curAddr <= '0;
			modulo  <= '0;
		end else if (advance) begin
			// Busy is high here so no strobe competes
			curAddr <= curAddr + modulo;
		end else if (accept) begin
			case (cpuReq.sel)
				REG_VRAMADDR: begin
					curAddr <= cpuReq.data[`VRAM_AW-1:0];
				end
				REG_VRAMMOD: begin
					modulo <= cpuReq.data[`VRAM_AW-1:0];
				end
				default: begin
					// Data writes handled below
				end
			endcase
		end
	end

	//============================================================
	// Pending write data
	//============================================================

	// Held until the write slot comes around
	always_ff @(posedge CLK) begin
		if (accept && (cpuReq.sel == REG_VRAMRW)) begin
			wrData <= cpuReq.data;
		end
	end

endmodule

`default_nettype wire

// File: vramArray.sv
//============================================================
// Memory contents are undefined after reset
//============================================================
`timescale 1ns/100ps
`default_nettype none

`include "lspc_cfg.svh"

module vramArray import lspcVramPkg::*; (
	input  wire                       CLK,
	input  wire                       nRESETP,
	input  wire memAccess_t           memReq,
	input  wire                       videoSlot,
	input  wire [`VRAM_AW-1:0]        vidAddr,
	output logic [`VRAM_DW-1:0]       readData,
	output logic [`VRAM_DW-1:0]       vidData,
	output logic                      vidValid
);

	logic [`VRAM_DW-1:0] mem [0:(1 << `VRAM_AW) - 1];

	// CPU write port and video read port
	always_ff @(posedge CLK) begin
		if (memReq.wrEn) begin
			mem[memReq.addr] <= memReq.data;
		end
		// Video address sampled in its slot only
		if (videoSlot) begin
			vidData <= mem[vidAddr];
		end
	end

	// Prefetch latch and video strobe
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			readData <= '0;
			vidValid <= 1'b0;
		end else begin
			vidValid <= videoSlot;
			// Holds the word at the current address between prefetches
			if (memReq.rdEn) begin
				readData <= mem[memReq.addr];
			end
		end
	end

endmodule

`default_nettype wire

// File: lspcVram.sv
//============================================================
// No back-pressure so watch busy before each strobe
// readData is valid only while busy is low
//============================================================
`timescale 1ns/100ps
`default_nettype none

`include "lspc_cfg.svh"

module lspcVram import lspcCpuPkg::*, lspcVramPkg::*; (
	input  wire                       CLK,
	input  wire                       nRESETP,
	input  wire cpuReq_t              cpuReq,
	input  wire [`VRAM_AW-1:0]        vidAddr,
	output logic [`VRAM_DW-1:0]       readData,
	output logic                      busy,
	output logic [`VRAM_DW-1:0]       vidData,
	output logic                      vidValid
);

	// Slot strobes
	logic                videoSlot;
	logic                cpuSlot;

	// Sequencer to array
	memAccess_t          memReq;

	// Address path
	logic [`VRAM_AW-1:0] curAddr;
	logic [`VRAM_DW-1:0] wrData;
	logic                advance;

	slotTimer timerInst (
		.CLK       (CLK),
		.nRESETP   (nRESETP),
		.videoSlot (videoSlot),
		.cpuSlot   (cpuSlot)
	);

	vramSequencer seqInst (
		.CLK     (CLK),
		.nRESETP (nRESETP),
		.cpuReq  (cpuReq),
		.cpuSlot (cpuSlot),
		.curAddr (curAddr),
		.wrData  (wrData),
		.memReq  (memReq),
		.advance (advance),
		.busy    (busy)
	);

	vramAddrRegs regsInst (
		.CLK     (CLK),
		.nRESETP (nRESETP),
		.cpuReq  (cpuReq),
		.busy    (busy),
		.advance (advance),
		.curAddr (curAddr),
		.wrData  (wrData)
	);

	vramArray memInst (
		.CLK       (CLK),
		.nRESETP   (nRESETP),
		.memReq    (memReq),
		.videoSlot (videoSlot),
		.vidAddr   (vidAddr),
		.readData  (readData),
		.vidData   (vidData),
		.vidValid  (vidValid)
	);

endmodule

`default_nettype wire

// File: lspcVram_assertions.sv
//============================================================
// Bound into every vramSequencer, silent while in reset
//============================================================
`timescale 1ns/100ps
`default_nettype none

`include "lspc_cfg.svh"

module lspcVramAssertions import lspcVramPkg::*; (
	input wire             CLK,
	input wire             nRESETP,
	input wire             cpuSlot,
	input wire             busy,
	input wire memAccess_t memReq,
	input wire seqState_e  state
);

	// Write slot and prefetch slot are one access period apart
	writeThenPrefetch: assert property (@(posedge CLK) disable iff (!nRESETP)
		memReq.wrEn |-> cpuSlot ##`SLOT_COUNT (memReq.rdEn && cpuSlot))
		else $error("prefetch did not follow the write in the next CPU slot");

	// Worst case is a data strobe right after a CPU slot
	busyBounded: assert property (@(posedge CLK) disable iff (!nRESETP)
		$rose(busy) |-> ##[1:2*`SLOT_COUNT+1] !busy)
		else $error("busy held longer than two access periods");

	stateLegal: assert property (@(posedge CLK) disable iff (!nRESETP)
		state inside {IDLE, WRITE_WAIT, PREFETCH_WAIT})
		else $error("sequencer state outside its enum");

endmodule

bind vramSequencer lspcVramAssertions seqChecks (.*);

`default_nettype wire

// File: tbLspcVram.sv
//============================================================
// Directed tests against a memory model, stops at first error
// Words never written are never compared
//============================================================
`timescale 1ns/100ps
`default_nettype none

`include "lspc_cfg.svh"

module tbLspcVram import lspcCpuPkg::*, lspcVramPkg::*; ();

	localparam int ClkPeriod = 4;
	localparam int BusyLimit = 2 * `SLOT_COUNT + 1;
	localparam int BurstLen  = 8;
	localparam int StepCount = 6;
	// Strobes issued by all tests together
	localparam int StrobeCount = 3 + (2 + 2 * BurstLen) + (2 + 2 * StepCount) + 12;
	// Reset, video pulse waits and slack
	localparam int MarginCycles = 8 + 12 * `SLOT_COUNT + 200;

	logic                CLK;
	logic                nRESETP;
	cpuReq_t             cpuReq;
	logic [`VRAM_AW-1:0] vidAddr;
	logic [`VRAM_DW-1:0] readData;
	logic                busy;
	logic [`VRAM_DW-1:0] vidData;
	logic                vidValid;

	//============================================================
	// Reference model
	//============================================================
	logic [`VRAM_DW-1:0] modelMem [0:(1 << `VRAM_AW) - 1];
	bit                  modelKnown [0:(1 << `VRAM_AW) - 1];
	logic [`VRAM_AW-1:0] modelAddr;
	logic [`VRAM_AW-1:0] modelMod;
	logic [`VRAM_AW-1:0] writtenQ [$];
	string               curTest;

	lspcVram UUT (
		.CLK      (CLK),
		.nRESETP  (nRESETP),
		.cpuReq   (cpuReq),
		.vidAddr  (vidAddr),
		.readData (readData),
		.busy     (busy),
		.vidData  (vidData),
		.vidValid (vidValid)
	);

	initial begin
		CLK = 1'b0;
		forever #(ClkPeriod / 2) CLK = ~CLK;
	end

	// Whole run bounded by worst case strobe latency
	initial begin
		#(ClkPeriod * (StrobeCount * BusyLimit + MarginCycles));
		$display("Watchdog timeout, the tests did not finish in time");
		$display("Test FAILED");
		$fatal(1);
	end

	task automatic checkEq(input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("** Error: %s expected 0x%0h actual 0x%0h", curTest, expected, actual);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic failPlain(input string what);
		$display("%s: %s", curTest, what);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// One strobe cycle, driven between falling edges
	task automatic pulseReg(input cpuReg_e sel, input logic [`VRAM_DW-1:0] data);
		@(negedge CLK);
		cpuReq.strobe = 1'b1;
		cpuReq.sel    = sel;
		cpuReq.data   = data;
		@(negedge CLK);
		cpuReq.strobe = 1'b0;
	endtask

	task automatic waitIdle();
		int n;
		n = 0;
		while (busy) begin
			if (n > BusyLimit) failPlain("busy did not fall in time");
			@(negedge CLK);
			n++;
		end
	endtask

	// Cycles from the call to the next vidValid sample
	task automatic waitVid(output int cycles);
		@(negedge CLK);
		cycles = 1;
		while (!vidValid) begin
			if (cycles > BusyLimit) failPlain("vidValid did not pulse");
			@(negedge CLK);
			cycles++;
		end
	endtask

	// Prefetched word must match the model at the current address
	task automatic checkPrefetch();
		checkEq(modelAddr, UUT.regsInst.curAddr);
		if (modelKnown[modelAddr]) begin
			checkEq(modelMem[modelAddr], readData);
		end
	endtask

	task automatic setAddr(input logic [`VRAM_AW-1:0] a);
		pulseReg(REG_VRAMADDR, 16'(a));
		checkEq(1'b1, busy);
		waitIdle();
		modelAddr = a;
		checkPrefetch();
	endtask

	// Modulo load leaves the port idle
	task automatic setMod(input logic [`VRAM_AW-1:0] m);
		pulseReg(REG_VRAMMOD, 16'(m));
		checkEq(1'b0, busy);
		modelMod = m;
	endtask

	task automatic startWrite(input logic [`VRAM_DW-1:0] d);
		pulseReg(REG_VRAMRW, d);
		checkEq(1'b1, busy);
	endtask

	// Store at the old address, then step by the modulo
	task automatic finishWrite(input logic [`VRAM_DW-1:0] d);
		waitIdle();
		modelMem[modelAddr]   = d;
		modelKnown[modelAddr] = 1'b1;
		writtenQ.push_back(modelAddr);
		modelAddr = `VRAM_AW'(modelAddr + modelMod);
		checkPrefetch();
	endtask

	task automatic writeWord(input logic [`VRAM_DW-1:0] d);
		startWrite(d);
		finishWrite(d);
	endtask

	//============================================================
	// Tests
	//============================================================
	task automatic testReset();
		int cycles;
		curTest = "reset";
		checkEq(1'b0, busy);
		checkEq(1'b0, vidValid);
		checkEq(0, readData);
		checkEq(IDLE, UUT.seqInst.state);
		waitVid(cycles);
		// Pulse spacing is one full access period
		repeat (3) begin
			waitVid(cycles);
			checkEq(`SLOT_COUNT, cycles);
		end
	endtask

	task automatic testSingle();
		logic [`VRAM_AW-1:0] a;
		logic [`VRAM_DW-1:0] d;
		curTest = "single write";
		a = `VRAM_AW'($urandom);
		d = 16'($urandom);
		setAddr(a);
		writeWord(d);
		setAddr(a);
		checkEq(d, readData);
	endtask

	task automatic testBurst();
		logic [`VRAM_AW-1:0] start;
		logic [`VRAM_DW-1:0] words [BurstLen];
		curTest = "burst modulo 1";
		start = `VRAM_AW'($urandom);
		setMod(1);
		setAddr(start);
		for (int i = 0; i < BurstLen; i++) begin
			words[i] = 16'($urandom);
			writeWord(words[i]);
		end
		for (int i = 0; i < BurstLen; i++) begin
			setAddr(`VRAM_AW'(start + i));
			checkEq(words[i], readData);
		end
	endtask

	task automatic testStride();
		logic [`VRAM_AW-1:0] mod;
		logic [`VRAM_AW-1:0] landing [StepCount];
		curTest = "stride modulo";
		// Six steps of at least 0x200 always wrap
		mod = `VRAM_AW'(32'h200 | ($urandom & 32'h1ff));
		setMod(mod);
		setAddr(`VRAM_AW'($urandom));
		for (int i = 0; i < StepCount; i++) begin
			landing[i] = modelAddr;
			writeWord(16'($urandom));
		end
		for (int i = 0; i < StepCount; i++) begin
			setAddr(landing[i]);
			checkEq(modelMem[landing[i]], readData);
		end
	endtask

	task automatic testIgnored();
		logic [`VRAM_AW-1:0] a;
		logic [`VRAM_DW-1:0] d;
		curTest = "strobe while busy";
		a = `VRAM_AW'($urandom);
		setMod(1);
		setAddr(a);
		repeat (3) writeWord(16'($urandom));
		setAddr(a);
		d = 16'($urandom);
		startWrite(d);
		// Each of these lands while the write is still pending
		@(negedge CLK);
		checkEq(1'b1, busy);
		pulseReg(REG_VRAMADDR, 16'(`VRAM_AW'(a + 7)));
		checkEq(1'b1, busy);
		pulseReg(REG_VRAMMOD, 16'd3);
		checkEq(1'b1, busy);
		pulseReg(REG_VRAMRW, 16'($urandom));
		finishWrite(d);
		// A modulo of 3 would land past the known words
		writeWord(16'($urandom));
		setAddr(a);
		checkEq(d, readData);
	endtask

	task automatic testVideo();
		logic [`VRAM_AW-1:0] a;
		int                  cycles;
		curTest = "video fetch";
		repeat (3) begin
			a = writtenQ[$urandom_range(writtenQ.size() - 1, 0)];
			@(negedge CLK);
			vidAddr = a;
			// First pulse may still carry the old address
			waitVid(cycles);
			waitVid(cycles);
			checkEq(modelMem[a], vidData);
		end
	endtask

	initial begin
		void'($urandom(32'hdc2d4baa));
		nRESETP   = 1'b0;
		cpuReq    = '0;
		vidAddr   = '0;
		modelAddr = '0;
		modelMod  = '0;
		repeat (8) @(posedge CLK);
		@(negedge CLK);
		nRESETP = 1'b1;
		testReset();
		testSingle();
		testBurst();
		testStride();
		testIgnored();
		testVideo();
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
lspcCpuPkg.sv
lspcVramPkg.sv
slotTimer.sv
vramSequencer.sv
vramAddrRegs.sv
vramArray.sv
lspcVram.sv
lspcVram_assertions.sv
tbLspcVram.sv

// File: Bender.yml
package:
  name: lspc_vram

sources:
  - include_dirs:
      - .
    files:
      - lspcCpuPkg.sv
      - lspcVramPkg.sv
      - slotTimer.sv
      - vramSequencer.sv
      - vramAddrRegs.sv
      - vramArray.sv
      - lspcVram.sv
  - target: test
    include_dirs:
      - .
    files:
      - lspcVram_assertions.sv
      - tbLspcVram.sv
